// ==== verilog/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    // datapath widths
    localparam int unsigned WORD_W  = 32;
    localparam int unsigned REG_W   = 5;
    localparam int unsigned SHAMT_W = 5;

    // execute/memory buffer, also the decode credit count after reset
    localparam int unsigned BUF_DEPTH = 2;

    // credits the memory stage grants after reset
    localparam int unsigned OUT_CREDITS = 2;

    // derived widths for the buffer pointers, occupancy and credit counter
    localparam int unsigned BUF_PTR_W = $clog2(BUF_DEPTH);
    localparam int unsigned BUF_CNT_W = $clog2(BUF_DEPTH + 1);
    localparam int unsigned CREDIT_W  = $clog2(OUT_CREDITS + 1);

    localparam logic [BUF_PTR_W-1:0] BUF_LAST    = BUF_PTR_W'(BUF_DEPTH - 1);
    localparam logic [CREDIT_W-1:0]  CREDIT_FULL = CREDIT_W'(OUT_CREDITS);

    // jal / jalr write here
    localparam logic [REG_W-1:0] LINK_REG = 5'd31;

    // alu operations; mult/multu only feed the multiply unit
    typedef enum logic [3:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        LUI,
        MULT,
        MULTU
    } aluOp_t;

    // destination register field
    typedef enum logic [1:0] {
        RT,
        RD,
        RA
    } regDst_t;

    // forwarding source chosen by the hazard unit
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } forward_t;

    // second alu operand
    typedef enum logic [1:0] {
        SRCB_REG,
        SRCB_IMM,
        SRCB_SHAMT
    } srcBSel_t;

endpackage

`default_nettype wire

// ==== verilog/operandForward.sv ====
`timescale 1ns/1ns
`default_nettype none

module operandForward (
    input  wire logic [mipsPkg::WORD_W-1:0] srcA,
    input  wire logic [mipsPkg::WORD_W-1:0] srcB,
    input  wire logic [mipsPkg::WORD_W-1:0] aluOutM,
    input  wire logic [mipsPkg::WORD_W-1:0] resultW,
    input  wire mipsPkg::forward_t          forwardA,
    input  wire mipsPkg::forward_t          forwardB,
    output logic      [mipsPkg::WORD_W-1:0] fwdA,
    output logic      [mipsPkg::WORD_W-1:0] fwdB
);

    // register value unless a younger result is still in flight
    function automatic logic [mipsPkg::WORD_W-1:0] pickSource(
        input logic [mipsPkg::WORD_W-1:0] regVal,
        input logic [mipsPkg::WORD_W-1:0] memVal,
        input logic [mipsPkg::WORD_W-1:0] wbVal,
        input mipsPkg::forward_t          sel
    );
        logic [mipsPkg::WORD_W-1:0] picked;
        case (sel)
            mipsPkg::FWD_MEM: picked = memVal;
            mipsPkg::FWD_WB:  picked = wbVal;
            default:          picked = regVal;
        endcase
        return picked;
    endfunction

    assign fwdA = pickSource(srcA, aluOutM, resultW, forwardA);

    // also the store data
    assign fwdB = pickSource(srcB, aluOutM, resultW, forwardB);

endmodule

`default_nettype wire

// ==== verilog/aluCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluCore (
    input  wire logic [mipsPkg::WORD_W-1:0] a,
    input  wire logic [mipsPkg::WORD_W-1:0] b,
    input  wire mipsPkg::aluOp_t            op,
    output logic      [mipsPkg::WORD_W-1:0] y,
    output logic                            overflow
);

    logic [mipsPkg::WORD_W-1:0] sum;
    logic [mipsPkg::WORD_W-1:0] diff;
    logic                       sumOvf;
    logic                       diffOvf;
    logic                       ltSigned;
    logic                       ltUnsigned;
    logic [4:0]                 shiftAmt;

    assign sum  = a + b;
    assign diff = a - b;

    // same-sign inputs, result sign flipped
    assign sumOvf = (a[mipsPkg::WORD_W-1] == b[mipsPkg::WORD_W-1]) &&
                    (sum[mipsPkg::WORD_W-1] != a[mipsPkg::WORD_W-1]);

    // opposite-sign inputs, result takes the sign of b
    assign diffOvf = (a[mipsPkg::WORD_W-1] != b[mipsPkg::WORD_W-1]) &&
                     (diff[mipsPkg::WORD_W-1] != a[mipsPkg::WORD_W-1]);

    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    // shifts move b, amount sits in a
    assign shiftAmt = a[4:0];

    always_comb begin
        y        = '0;
        overflow = 1'b0;
        case (op)
            mipsPkg::ADD: begin
                y        = sum;
                overflow = sumOvf;
            end
            mipsPkg::ADDU: y = sum;
            mipsPkg::SUB: begin
                y        = diff;
                overflow = diffOvf;
            end
            mipsPkg::SUBU: y = diff;
            mipsPkg::AND:  y = a & b;
            mipsPkg::OR:   y = a | b;
            mipsPkg::XOR:  y = a ^ b;
            mipsPkg::NOR:  y = ~(a | b);
            mipsPkg::SLT:  y = {{(mipsPkg::WORD_W-1){1'b0}}, ltSigned};
            mipsPkg::SLTU: y = {{(mipsPkg::WORD_W-1){1'b0}}, ltUnsigned};
            mipsPkg::SLL:  y = b << shiftAmt;
            mipsPkg::SRL:  y = b >> shiftAmt;
            mipsPkg::SRA:  y = $signed(b) >>> shiftAmt;
            mipsPkg::LUI:  y = {b[15:0], 16'h0000};
            // mult/multu leave y at zero
            default:       y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/multUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module multUnit (
    input  wire logic [mipsPkg::WORD_W-1:0] a,
    input  wire logic [mipsPkg::WORD_W-1:0] b,
    input  wire mipsPkg::aluOp_t            op,
    output logic      [mipsPkg::WORD_W-1:0] hi,
    output logic      [mipsPkg::WORD_W-1:0] lo,
    output logic                            hiLoWrite
);

    logic signed [2*mipsPkg::WORD_W-1:0] prodSigned;
    logic        [2*mipsPkg::WORD_W-1:0] prodUnsigned;

    // operands widen to 64 bits before the multiply
    assign prodSigned   = $signed({{mipsPkg::WORD_W{a[mipsPkg::WORD_W-1]}}, a}) *
                          $signed({{mipsPkg::WORD_W{b[mipsPkg::WORD_W-1]}}, b});
    assign prodUnsigned = {{mipsPkg::WORD_W{1'b0}}, a} * {{mipsPkg::WORD_W{1'b0}}, b};

    always_comb begin
        {hi, lo}  = '0;
        hiLoWrite = 1'b0;
        if (op == mipsPkg::MULT) begin
            {hi, lo}  = prodSigned;
            hiLoWrite = 1'b1;
        end else if (op == mipsPkg::MULTU) begin
            {hi, lo}  = prodUnsigned;
            hiLoWrite = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  wire logic [mipsPkg::WORD_W-1:0]  fwdA,
    input  wire logic [mipsPkg::WORD_W-1:0]  fwdB,
    input  wire logic [mipsPkg::WORD_W-1:0]  imm,
    input  wire logic [mipsPkg::WORD_W-1:0]  pcPlus4,
    input  wire logic [mipsPkg::SHAMT_W-1:0] shamt,
    input  wire logic [mipsPkg::REG_W-1:0]   rt,
    input  wire logic [mipsPkg::REG_W-1:0]   rd,
    input  wire mipsPkg::aluOp_t             aluOp,
    input  wire mipsPkg::srcBSel_t           srcBSel,
    input  wire mipsPkg::regDst_t            regDst,
    input  wire logic                        isLink,
    output logic      [mipsPkg::WORD_W-1:0]  aluOut,
    output logic      [mipsPkg::WORD_W-1:0]  writeData,
    output logic      [mipsPkg::WORD_W-1:0]  hi,
    output logic      [mipsPkg::WORD_W-1:0]  lo,
    output logic      [mipsPkg::REG_W-1:0]   writeReg,
    output logic                             overflow,
    output logic                             hiLoWrite
);

    logic [mipsPkg::WORD_W-1:0] shamtExt;
    logic [mipsPkg::WORD_W-1:0] srcBMux;
    logic [mipsPkg::WORD_W-1:0] aluA;
    logic [mipsPkg::WORD_W-1:0] aluB;
    logic [mipsPkg::WORD_W-1:0] aluY;
    logic                       isShift;

    assign shamtExt = {{(mipsPkg::WORD_W-mipsPkg::SHAMT_W){1'b0}}, shamt};

    assign isShift = (aluOp == mipsPkg::SLL) || (aluOp == mipsPkg::SRL) ||
                     (aluOp == mipsPkg::SRA);

    always_comb begin
        case (srcBSel)
            mipsPkg::SRCB_IMM:   srcBMux = imm;
            mipsPkg::SRCB_SHAMT: srcBMux = shamtExt;
            default:             srcBMux = fwdB;
        endcase
    end

    // shifts: amount on A (shamt field or rs for variable shifts), rt value on B
    always_comb begin
        aluA = fwdA;
        aluB = srcBMux;
        if (isShift) begin
            aluA = (srcBSel == mipsPkg::SRCB_SHAMT) ? shamtExt : fwdA;
            aluB = fwdB;
        end
    end

    aluCore aluCore_inst (
        .a        (aluA),
        .b        (aluB),
        .op       (aluOp),
        .y        (aluY),
        .overflow (overflow)
    );

    multUnit multUnit_inst (
        .a         (aluA),
        .b         (aluB),
        .op        (aluOp),
        .hi        (hi),
        .lo        (lo),
        .hiLoWrite (hiLoWrite)
    );

    // link writes return address pc+8
    assign aluOut = isLink ? (pcPlus4 + 32'd4) : aluY;

    always_comb begin
        case (regDst)
            mipsPkg::RD: writeReg = rd;
            mipsPkg::RA: writeReg = mipsPkg::LINK_REG;
            default:     writeReg = rt;
        endcase
    end

    assign writeData = fwdB;

endmodule

`default_nettype wire

// ==== verilog/execMemReg.sv ====
`timescale 1ns/1ns
`default_nettype none

module execMemReg (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      inValid,
    input  wire logic [mipsPkg::WORD_W-1:0] aluOutIn,
    input  wire logic [mipsPkg::WORD_W-1:0] writeDataIn,
    input  wire logic [mipsPkg::WORD_W-1:0] hiIn,
    input  wire logic [mipsPkg::WORD_W-1:0] loIn,
    input  wire logic [mipsPkg::REG_W-1:0]  writeRegIn,
    input  wire logic                      overflowIn,
    input  wire logic                      hiLoWriteIn,
    input  wire logic                      outCredit,
    output logic                           outValid,
    output logic                           inCredit,
    output logic      [mipsPkg::WORD_W-1:0] aluOut,
    output logic      [mipsPkg::WORD_W-1:0] writeData,
    output logic      [mipsPkg::WORD_W-1:0] hi,
    output logic      [mipsPkg::WORD_W-1:0] lo,
    output logic      [mipsPkg::REG_W-1:0]  writeReg,
    output logic                           overflow,
    output logic                           hiLoWrite
);

    logic [mipsPkg::WORD_W-1:0] aluOutMem    [mipsPkg::BUF_DEPTH];
    logic [mipsPkg::WORD_W-1:0] writeDataMem [mipsPkg::BUF_DEPTH];
    logic [mipsPkg::WORD_W-1:0] hiMem        [mipsPkg::BUF_DEPTH];
    logic [mipsPkg::WORD_W-1:0] loMem        [mipsPkg::BUF_DEPTH];
    logic [mipsPkg::REG_W-1:0]  writeRegMem  [mipsPkg::BUF_DEPTH];
    logic                       overflowMem  [mipsPkg::BUF_DEPTH];
    logic                       hiLoWriteMem [mipsPkg::BUF_DEPTH];

    logic [mipsPkg::BUF_PTR_W-1:0] wrPtr;
    logic [mipsPkg::BUF_PTR_W-1:0] rdPtr;
    logic [mipsPkg::BUF_CNT_W-1:0] count;
    logic [mipsPkg::CREDIT_W-1:0]  credits;

    // decode only sends while it holds a credit, so a push never meets a full buffer
    logic push;
    logic pop;

    assign push = inValid;

    // oldest entry leaves whenever memory has room for it
    assign pop      = (count != '0) && (credits != '0);
    assign outValid = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            aluOutMem[wrPtr]    <= aluOutIn;
            writeDataMem[wrPtr] <= writeDataIn;
            hiMem[wrPtr]        <= hiIn;
            loMem[wrPtr]        <= loIn;
            writeRegMem[wrPtr]  <= writeRegIn;
            overflowMem[wrPtr]  <= overflowIn;
            hiLoWriteMem[wrPtr] <= hiLoWriteIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            credits  <= mipsPkg::CREDIT_FULL;
            inCredit <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == mipsPkg::BUF_LAST) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == mipsPkg::BUF_LAST) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // spend and refill can land in the same cycle
            case ({pop, outCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            // slot freed, hand a credit back to decode
            inCredit <= pop;
        end
    end

    assign aluOut    = aluOutMem[rdPtr];
    assign writeData = writeDataMem[rdPtr];
    assign hi        = hiMem[rdPtr];
    assign lo        = loMem[rdPtr];
    assign writeReg  = writeRegMem[rdPtr];
    assign overflow  = overflowMem[rdPtr];
    assign hiLoWrite = hiLoWriteMem[rdPtr];

endmodule

`default_nettype wire

// ==== verilog/execTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module execTop (
    input  wire logic                        clk,
    input  wire logic                        rst,
    // decode side
    input  wire logic                        inValid,
    input  wire mipsPkg::aluOp_t             aluOp,
    input  wire mipsPkg::srcBSel_t           srcBSel,
    input  wire mipsPkg::regDst_t            regDst,
    input  wire logic                        isLink,
    input  wire logic [mipsPkg::WORD_W-1:0]  srcA,
    input  wire logic [mipsPkg::WORD_W-1:0]  srcB,
    input  wire logic [mipsPkg::WORD_W-1:0]  imm,
    input  wire logic [mipsPkg::SHAMT_W-1:0] shamt,
    input  wire logic [mipsPkg::REG_W-1:0]   rt,
    input  wire logic [mipsPkg::REG_W-1:0]   rd,
    input  wire logic [mipsPkg::WORD_W-1:0]  pcPlus4,
    output logic                             inCredit,
    // hazard unit
    input  wire mipsPkg::forward_t           forwardA,
    input  wire mipsPkg::forward_t           forwardB,
    input  wire logic [mipsPkg::WORD_W-1:0]  aluOutM,
    input  wire logic [mipsPkg::WORD_W-1:0]  resultW,
    // memory side
    input  wire logic                        outCredit,
    output logic                             outValid,
    output logic      [mipsPkg::WORD_W-1:0]  aluOut,
    output logic      [mipsPkg::REG_W-1:0]   writeReg,
    output logic      [mipsPkg::WORD_W-1:0]  writeData,
    output logic      [mipsPkg::WORD_W-1:0]  hi,
    output logic      [mipsPkg::WORD_W-1:0]  lo,
    output logic                             overflow,
    output logic                             hiLoWrite
);

    logic [mipsPkg::WORD_W-1:0] fwdA;
    logic [mipsPkg::WORD_W-1:0] fwdB;
    logic [mipsPkg::WORD_W-1:0] aluOutE;
    logic [mipsPkg::WORD_W-1:0] writeDataE;
    logic [mipsPkg::WORD_W-1:0] hiE;
    logic [mipsPkg::WORD_W-1:0] loE;
    logic [mipsPkg::REG_W-1:0]  writeRegE;
    logic                       overflowE;
    logic                       hiLoWriteE;

    operandForward operandForward_inst (
        .srcA     (srcA),
        .srcB     (srcB),
        .aluOutM  (aluOutM),
        .resultW  (resultW),
        .forwardA (forwardA),
        .forwardB (forwardB),
        .fwdA     (fwdA),
        .fwdB     (fwdB)
    );

    executeStage executeStage_inst (
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .imm       (imm),
        .pcPlus4   (pcPlus4),
        .shamt     (shamt),
        .rt        (rt),
        .rd        (rd),
        .aluOp     (aluOp),
        .srcBSel   (srcBSel),
        .regDst    (regDst),
        .isLink    (isLink),
        .aluOut    (aluOutE),
        .writeData (writeDataE),
        .hi        (hiE),
        .lo        (loE),
        .writeReg  (writeRegE),
        .overflow  (overflowE),
        .hiLoWrite (hiLoWriteE)
    );

    execMemReg execMemReg_inst (
        .clk         (clk),
        .rst         (rst),
        .inValid     (inValid),
        .aluOutIn    (aluOutE),
        .writeDataIn (writeDataE),
        .hiIn        (hiE),
        .loIn        (loE),
        .writeRegIn  (writeRegE),
        .overflowIn  (overflowE),
        .hiLoWriteIn (hiLoWriteE),
        .outCredit   (outCredit),
        .outValid    (outValid),
        .inCredit    (inCredit),
        .aluOut      (aluOut),
        .writeData   (writeData),
        .hi          (hi),
        .lo          (lo),
        .writeReg    (writeReg),
        .overflow    (overflow),
        .hiLoWrite   (hiLoWrite)
    );

endmodule

`default_nettype wire

// ==== sim/execTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module execTb;

    localparam int EXP_W          = 4 * mipsPkg::WORD_W + mipsPkg::REG_W + 2;
    localparam int CREDIT_TIMEOUT = 300;
    localparam int DRAIN_TIMEOUT  = 400;
    localparam int RANDOM_COUNT   = 300;

    logic                          clk;
    logic                          rst;
    logic                          inValid;
    mipsPkg::aluOp_t               aluOp;
    mipsPkg::srcBSel_t             srcBSel;
    mipsPkg::regDst_t              regDst;
    logic                          isLink;
    logic [mipsPkg::WORD_W-1:0]    srcA;
    logic [mipsPkg::WORD_W-1:0]    srcB;
    logic [mipsPkg::WORD_W-1:0]    imm;
    logic [mipsPkg::SHAMT_W-1:0]   shamt;
    logic [mipsPkg::REG_W-1:0]     rt;
    logic [mipsPkg::REG_W-1:0]     rd;
    logic [mipsPkg::WORD_W-1:0]    pcPlus4;
    logic                          inCredit;
    mipsPkg::forward_t             forwardA;
    mipsPkg::forward_t             forwardB;
    logic [mipsPkg::WORD_W-1:0]    aluOutM;
    logic [mipsPkg::WORD_W-1:0]    resultW;
    logic                          outCredit;
    logic                          outValid;
    logic [mipsPkg::WORD_W-1:0]    aluOut;
    logic [mipsPkg::REG_W-1:0]     writeReg;
    logic [mipsPkg::WORD_W-1:0]    writeData;
    logic [mipsPkg::WORD_W-1:0]    hi;
    logic [mipsPkg::WORD_W-1:0]    lo;
    logic                          overflow;
    logic                          hiLoWrite;

    integer           seed;
    int               decodeCredits;
    int               downCredits;
    int               pendingReturns;
    logic             forceHold;
    logic             stopRun;
    int               checkCount;
    int               valueErrors;
    int               protocolErrors;
    int               timeoutErrors;
    logic [EXP_W-1:0] expQ [$];

    execTop execTop_inst (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .aluOp     (aluOp),
        .srcBSel   (srcBSel),
        .regDst    (regDst),
        .isLink    (isLink),
        .srcA      (srcA),
        .srcB      (srcB),
        .imm       (imm),
        .shamt     (shamt),
        .rt        (rt),
        .rd        (rd),
        .pcPlus4   (pcPlus4),
        .inCredit  (inCredit),
        .forwardA  (forwardA),
        .forwardB  (forwardB),
        .aluOutM   (aluOutM),
        .resultW   (resultW),
        .outCredit (outCredit),
        .outValid  (outValid),
        .aluOut    (aluOut),
        .writeReg  (writeReg),
        .writeData (writeData),
        .hi        (hi),
        .lo        (lo),
        .overflow  (overflow),
        .hiLoWrite (hiLoWrite)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkWord(input string name, input logic [mipsPkg::WORD_W-1:0] expected,
                             input logic [mipsPkg::WORD_W-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
            valueErrors++;
        end
    endtask

    task automatic checkReg(input string name, input logic [mipsPkg::REG_W-1:0] expected,
                            input logic [mipsPkg::REG_W-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
            valueErrors++;
        end
    endtask

    task automatic flagProtocol(input string what);
        $display("ERROR: %s at %0t", what, $time);
        protocolErrors++;
    endtask

    function automatic logic [mipsPkg::WORD_W-1:0] forwardedValue(
        input mipsPkg::forward_t          sel,
        input logic [mipsPkg::WORD_W-1:0] regVal,
        input logic [mipsPkg::WORD_W-1:0] memVal,
        input logic [mipsPkg::WORD_W-1:0] wbVal
    );
        if (sel == mipsPkg::FWD_MEM) begin
            return memVal;
        end else if (sel == mipsPkg::FWD_WB) begin
            return wbVal;
        end
        return regVal;
    endfunction

    // expected {aluOut, writeReg, writeData, hi, lo, overflow, hiLoWrite}
    function automatic logic [EXP_W-1:0] refExecute(
        input mipsPkg::aluOp_t             op,
        input mipsPkg::srcBSel_t           bSel,
        input mipsPkg::regDst_t            dst,
        input logic                        link,
        input logic [mipsPkg::WORD_W-1:0]  a,
        input logic [mipsPkg::WORD_W-1:0]  b,
        input logic [mipsPkg::WORD_W-1:0]  immVal,
        input logic [mipsPkg::WORD_W-1:0]  pc4,
        input logic [mipsPkg::SHAMT_W-1:0] sh,
        input logic [mipsPkg::REG_W-1:0]   rtVal,
        input logic [mipsPkg::REG_W-1:0]   rdVal
    );
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] y;
        logic [31:0] hiV;
        logic [31:0] loV;
        logic [32:0] wide;
        logic [63:0] big;
        logic [4:0]  wReg;
        logic        ovf;
        logic        hlw;
        opA = a;
        case (bSel)
            mipsPkg::SRCB_IMM:   opB = immVal;
            mipsPkg::SRCB_SHAMT: opB = {27'd0, sh};
            default:             opB = b;
        endcase
        // shifts take the amount on A and shift the rt value
        if (op == mipsPkg::SLL || op == mipsPkg::SRL || op == mipsPkg::SRA) begin
            opA = (bSel == mipsPkg::SRCB_SHAMT) ? {27'd0, sh} : a;
            opB = b;
        end
        y   = '0;
        hiV = '0;
        loV = '0;
        ovf = 1'b0;
        hlw = 1'b0;
        case (op)
            mipsPkg::ADD: begin
                wide = {opA[31], opA} + {opB[31], opB};
                y    = wide[31:0];
                ovf  = wide[32] ^ wide[31];
            end
            mipsPkg::ADDU: y = opA + opB;
            mipsPkg::SUB: begin
                wide = {opA[31], opA} - {opB[31], opB};
                y    = wide[31:0];
                ovf  = wide[32] ^ wide[31];
            end
            mipsPkg::SUBU: y = opA - opB;
            mipsPkg::AND:  y = opA & opB;
            mipsPkg::OR:   y = opA | opB;
            mipsPkg::XOR:  y = opA ^ opB;
            mipsPkg::NOR:  y = ~(opA | opB);
            // differing signs decide on their own
            mipsPkg::SLT:  y[0] = (opA[31] != opB[31]) ? opA[31] : (opA < opB);
            mipsPkg::SLTU: y[0] = opA < opB;
            mipsPkg::SLL:  y = opB << opA[4:0];
            mipsPkg::SRL:  y = opB >> opA[4:0];
            mipsPkg::SRA: begin
                big = {{32{opB[31]}}, opB} >> opA[4:0];
                y   = big[31:0];
            end
            mipsPkg::LUI:  y = {opB[15:0], 16'h0000};
            mipsPkg::MULT: begin
                big = {{32{opA[31]}}, opA} * {{32{opB[31]}}, opB};
                {hiV, loV} = big;
                hlw = 1'b1;
            end
            mipsPkg::MULTU: begin
                big = {32'd0, opA} * {32'd0, opB};
                {hiV, loV} = big;
                hlw = 1'b1;
            end
            default: y = '0;
        endcase
        if (link) begin
            y = pc4 + 32'd4;
        end
        case (dst)
            mipsPkg::RD: wReg = rdVal;
            mipsPkg::RA: wReg = 5'd31;
            default:     wReg = rtVal;
        endcase
        return {y, wReg, b, hiV, loV, ovf, hlw};
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic randomInstr();
        logic [31:0] r;
        logic [31:0] f;
        r = $random(seed);
        f = $random(seed);
        aluOp    = mipsPkg::aluOp_t'(r[3:0]);
        srcBSel  = mipsPkg::srcBSel_t'(2'(r[7:4] % 4'd3));
        regDst   = mipsPkg::regDst_t'(2'(r[11:8] % 4'd3));
        forwardA = mipsPkg::forward_t'(2'(r[15:12] % 4'd3));
        forwardB = mipsPkg::forward_t'(2'(r[19:16] % 4'd3));
        isLink   = (r[23:20] == 4'd0);
        shamt    = r[28:24];
        rt       = f[4:0];
        rd       = f[9:5];
        imm      = {{16{f[31]}}, f[31:16]};
        srcA     = $random(seed);
        srcB     = $random(seed);
        aluOutM  = $random(seed);
        resultW  = $random(seed);
        pcPlus4  = $random(seed);
        pcPlus4[1:0] = 2'b00;
    endtask

    // waits for a decode credit, then sends one instruction for one cycle
    task automatic issueInstr();
        int                         waitCycles;
        logic [mipsPkg::WORD_W-1:0] fa;
        logic [mipsPkg::WORD_W-1:0] fb;
        waitCycles = 0;
        while (decodeCredits == 0 && !stopRun) begin
            nextCycle();
            waitCycles++;
            if (waitCycles > CREDIT_TIMEOUT) begin
                $display("timeout: no decode credit came back within %0d cycles",
                         CREDIT_TIMEOUT);
                timeoutErrors++;
                stopRun = 1'b1;
            end
        end
        if (!stopRun) begin
            fa = forwardedValue(forwardA, srcA, aluOutM, resultW);
            fb = forwardedValue(forwardB, srcB, aluOutM, resultW);
            expQ.push_back(refExecute(aluOp, srcBSel, regDst, isLink, fa, fb, imm,
                                      pcPlus4, shamt, rt, rd));
            decodeCredits--;
            inValid = 1'b1;
            nextCycle();
            inValid = 1'b0;
        end
    endtask

    // all results out and every credit back on both sides
    task automatic drainAll();
        int waitCycles;
        waitCycles = 0;
        while (!stopRun && (expQ.size() != 0 ||
               decodeCredits != int'(mipsPkg::BUF_DEPTH) ||
               downCredits != int'(mipsPkg::OUT_CREDITS))) begin
            nextCycle();
            waitCycles++;
            if (waitCycles > DRAIN_TIMEOUT) begin
                $display("timeout: %0d results or some credits still missing after %0d cycles",
                         expQ.size(), DRAIN_TIMEOUT);
                timeoutErrors++;
                stopRun = 1'b1;
            end
        end
    endtask

    task automatic overflowCase(input logic [31:0] a, input logic [31:0] b);
        mipsPkg::aluOp_t arithOps [4] = '{mipsPkg::ADD, mipsPkg::ADDU,
                                          mipsPkg::SUB, mipsPkg::SUBU};
        for (int k = 0; k < 4; k++) begin
            randomInstr();
            aluOp    = arithOps[k];
            srcBSel  = mipsPkg::SRCB_REG;
            forwardA = mipsPkg::FWD_NONE;
            forwardB = mipsPkg::FWD_NONE;
            isLink   = 1'b0;
            srcA     = a;
            srcB     = b;
            issueInstr();
        end
    endtask

    // memory stage model, credits come back late and sometimes not for a while
    initial begin : memoryModel
        int          holdLeft;
        logic [31:0] r;
        logic        giveCredit;
        holdLeft       = 0;
        pendingReturns = 0;
        forever begin
            @(negedge clk);
            giveCredit = 1'b0;
            r = $random(seed);
            if (rst) begin
                pendingReturns = 0;
            end else if (outValid) begin
                pendingReturns++;
            end
            if (holdLeft > 0) begin
                holdLeft--;
            end else if (r[5:0] == 6'd0) begin
                holdLeft = 16 + int'(r[11:6]);
            end else if (pendingReturns > 0 && r[12] && !forceHold) begin
                giveCredit = 1'b1;
                pendingReturns--;
            end
            nextCycle();
            outCredit = giveCredit;
        end
    end

    // credit bookkeeping and scoreboard, sampled mid-cycle
    always @(negedge clk) begin : compareOutputs
        logic [mipsPkg::WORD_W-1:0] eAlu;
        logic [mipsPkg::WORD_W-1:0] eData;
        logic [mipsPkg::WORD_W-1:0] eHi;
        logic [mipsPkg::WORD_W-1:0] eLo;
        logic [mipsPkg::REG_W-1:0]  eReg;
        logic                       eOvf;
        logic                       eHlw;
        if (!rst) begin
            if (inCredit) begin
                if (decodeCredits >= int'(mipsPkg::BUF_DEPTH)) begin
                    flagProtocol("inCredit returned a credit that decode never spent");
                end else begin
                    decodeCredits++;
                end
            end
            if (outValid) begin
                if (downCredits == 0) begin
                    flagProtocol("outValid high with no downstream credit left");
                end else begin
                    downCredits--;
                end
                if (expQ.size() == 0) begin
                    flagProtocol("outValid high with no instruction outstanding");
                end else begin
                    {eAlu, eReg, eData, eHi, eLo, eOvf, eHlw} = expQ.pop_front();
                    checkWord("aluOut", eAlu, aluOut);
                    checkReg("writeReg", eReg, writeReg);
                    checkWord("writeData", eData, writeData);
                    checkWord("hi", eHi, hi);
                    checkWord("lo", eLo, lo);
                    checkFlag("overflow", eOvf, overflow);
                    checkFlag("hiLoWrite", eHlw, hiLoWrite);
                end
            end
            if (outCredit) begin
                downCredits++;
            end
        end
    end

    initial begin
        seed           = 32'hb328;
        rst            = 1'b1;
        inValid        = 1'b0;
        outCredit      = 1'b0;
        forceHold      = 1'b0;
        stopRun        = 1'b0;
        decodeCredits  = int'(mipsPkg::BUF_DEPTH);
        downCredits    = int'(mipsPkg::OUT_CREDITS);
        checkCount     = 0;
        valueErrors    = 0;
        protocolErrors = 0;
        timeoutErrors  = 0;
        randomInstr();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkFlag("outValid", 1'b0, outValid);
        checkFlag("inCredit", 1'b0, inCredit);
        nextCycle();

        // random mix of ops, operand sources and forwarding
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            randomInstr();
            issueInstr();
            if (seed[2:0] == 3'd0) begin
                nextCycle();
            end
        end

        overflowCase(32'h7fffffff, 32'h00000001);
        overflowCase(32'h80000000, 32'hffffffff);
        overflowCase(32'h80000000, 32'h00000001);
        overflowCase(32'h7fffffff, 32'hffffffff);
        overflowCase(32'h40000000, 32'h40000000);

        for (int i = 0; i < 12; i++) begin
            randomInstr();
            aluOp  = i[0] ? mipsPkg::MULTU : mipsPkg::MULT;
            isLink = 1'b0;
            issueInstr();
        end
        for (int i = 0; i < 9; i++) begin
            randomInstr();
            isLink = 1'b1;
            regDst = mipsPkg::regDst_t'(2'(i % 3));
            issueInstr();
        end

        // back-pressure: memory withholds, buffer fills, decode runs dry
        drainAll();
        forceHold = 1'b1;
        repeat (mipsPkg::BUF_DEPTH + mipsPkg::OUT_CREDITS) begin
            randomInstr();
            issueInstr();
        end
        repeat (20) nextCycle();
        if (!stopRun) begin
            if (decodeCredits != 0) begin
                flagProtocol("decode got a credit back while the buffer was full");
            end
            if (expQ.size() != int'(mipsPkg::BUF_DEPTH)) begin
                flagProtocol("buffer did not hold its entries under back-pressure");
            end
        end
        forceHold = 1'b0;
        drainAll();

        $display("checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 checkCount, valueErrors, protocolErrors, timeoutErrors);
        if (valueErrors + protocolErrors + timeoutErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/mipsPkg.sv
verilog/operandForward.sv
verilog/aluCore.sv
verilog/multUnit.sv
verilog/executeStage.sv
verilog/execMemReg.sv
verilog/execTop.sv
sim/execTb.sv

// ==== run.sh ====
#!/bin/sh
# build the execute stage testbench with Verilator, run it, then look for the pass line
verilator --binary --timescale 1ns/1ns --top-module execTb -f list.f \
    -Mdir obj_dir -o execSim > build.log 2>&1 &&
    ./obj_dir/execSim > sim.log 2>&1 &&
    grep -qx "TEST PASSED" sim.log &&
    echo "simulation passed" ||
    { echo "simulation failed, see build.log and sim.log"; exit 1; }
